// ==== Bender.yml ====
package:
  name: mem1

sources:
  - files:
      - design/mem_pkg.sv
      - design/tlb_lookup.sv
      - design/mem_excp_check.sv
      - design/store_align.sv
      - design/mem1_ctrl.sv
      - design/mem1_top.sv
  - target: test
    files:
      - tests/mem1_chk.sv
      - tests/mem1_tb.sv

// ==== design/mem1_ctrl.sv ====
`timescale 1ns/1ns

module mem1_ctrl #(
    parameter int LINE_OFS_BITS = 4,
    parameter int SET_BITS      = 6
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        advance_i,
    input  logic                        flush_i,
    input  logic                        valid_i,
    input  mem_pkg::mem_op_e            op_i,
    input  logic [mem_pkg::ADDR_W-1:0]  paddr_i,
    input  mem_pkg::excp_e              excp_i,
    input  logic                        uncache_i,
    input  logic [3:0]                  sel_i,
    input  mem_pkg::req_size_e          size_i,
    input  logic [mem_pkg::ADDR_W-1:0]  data_i,
    input  logic                        dcache_ready_i,
    output logic                        llbit_o,
    output logic                        advance_ready_o,
    output logic                        req_valid_o,
    output logic                        req_we_o,
    output logic [mem_pkg::ADDR_W-1:0]  req_addr_o,
    output logic [3:0]                  req_sel_o,
    output mem_pkg::req_size_e          req_size_o,
    output logic [mem_pkg::ADDR_W-1:0]  req_data_o,
    output logic                        req_uncache_o,
    output logic                        out_valid_o,
    output mem_pkg::mem_op_e            out_op_o,
    output mem_pkg::excp_e              out_excp_o,
    output logic [mem_pkg::ADDR_W-1:0]  out_paddr_o,
    output logic                        out_wreg_o,
    output logic [mem_pkg::ADDR_W-1:0]  out_wdata_o
);
    import mem_pkg::*;

    logic                is_load;
    logic                is_store;
    logic                is_sc;
    logic                mem_valid;
    logic                no_excp;
    logic                stage_go;
    logic [SET_BITS-1:0] cur_idx;
    logic                last_mem;
    logic [SET_BITS-1:0] last_idx;
    logic                last_mem_d;
    logic [SET_BITS-1:0] last_idx_d;
    logic                hazard;

    assign is_sc     = (op_i == OP_SC);
    assign is_load   = (op_i inside {OP_LD_B, OP_LD_BU, OP_LD_H, OP_LD_HU, OP_LD_W, OP_LL});
    assign is_store  = (op_i inside {OP_ST_B, OP_ST_H, OP_ST_W}) || (is_sc && llbit_o);
    assign mem_valid = valid_i && (is_load || is_store || is_sc);
    assign no_excp   = (excp_i == EXC_NONE);
    assign stage_go  = advance_i && dcache_ready_i;
    assign cur_idx   = paddr_i[LINE_OFS_BITS +: SET_BITS];

    // Set index of accesses from the last two cycles
    always_ff @(posedge clk) begin
        if (rst) begin
            last_mem <= 1'b0;
            last_idx <= '0;
        end else if (advance_i && mem_valid) begin
            last_mem <= 1'b1;
            last_idx <= cur_idx;
        end else if (dcache_ready_i) begin
            last_mem <= 1'b0;
            last_idx <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            last_mem_d <= 1'b0;
            last_idx_d <= '0;
        end else begin
            last_mem_d <= last_mem;
            last_idx_d <= last_idx;
        end
    end

    assign hazard = (last_mem && last_idx == cur_idx) || (last_mem_d && last_idx_d == cur_idx);
    assign advance_ready_o = mem_valid ? (dcache_ready_i && !hazard) : 1'b1;

    assign req_valid_o   = stage_go && valid_i && (is_load || is_store) && no_excp;
    assign req_we_o      = req_valid_o && is_store;
    assign req_addr_o    = req_valid_o ? paddr_i : '0;
    assign req_sel_o     = req_valid_o ? sel_i : 4'b0000;
    assign req_size_o    = req_valid_o ? size_i : SZ_BYTE;
    assign req_data_o    = req_we_o ? data_i : '0;
    assign req_uncache_o = req_valid_o && uncache_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            llbit_o <= 1'b0;
        end else if (stage_go && valid_i) begin
            if (op_i == OP_LL && no_excp) begin
                llbit_o <= 1'b1;
            end else if (is_sc) begin
                llbit_o <= 1'b0;
            end
        end
    end

    // Flush wins over advance
    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            out_valid_o <= 1'b0;
            out_op_o    <= OP_NONE;
            out_excp_o  <= EXC_NONE;
            out_paddr_o <= '0;
            out_wreg_o  <= 1'b0;
            out_wdata_o <= '0;
        end else if (stage_go) begin
            out_valid_o <= valid_i;
            out_op_o    <= valid_i ? op_i : OP_NONE;
            out_excp_o  <= valid_i ? excp_i : EXC_NONE;
            out_paddr_o <= paddr_i;
            out_wreg_o  <= valid_i && no_excp && (is_load || is_sc);
            // SC reports success from the LL bit it saw
            out_wdata_o <= {{(ADDR_W-1){1'b0}}, valid_i && is_sc && llbit_o};
        end
    end

endmodule

// ==== design/mem1_top.sv ====
`timescale 1ns/1ns

module mem1_top #(
    parameter int TLB_ENTRIES   = 8,
    parameter int LINE_OFS_BITS = 4,
    parameter int SET_BITS      = 6
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            valid_i,
    input  mem_pkg::mem_op_e                op_i,
    input  logic [mem_pkg::ADDR_W-1:0]      vaddr_i,
    input  logic [mem_pkg::ADDR_W-1:0]      wdata_i,
    input  logic [1:0]                      plv_i,
    input  logic                            trans_en_i,
    input  logic                            uncache_i,
    input  logic                            advance_i,
    input  logic                            flush_i,
    input  logic                            dcache_ready_i,
    input  logic                            tlb_we_i,
    input  logic [$clog2(TLB_ENTRIES)-1:0]  tlb_widx_i,
    input  logic [mem_pkg::PPN_W-1:0]       tlb_vppn_i,
    input  logic [mem_pkg::PPN_W-1:0]       tlb_ppn_i,
    input  logic                            tlb_v_i,
    input  logic                            tlb_d_i,
    input  logic [1:0]                      tlb_plv_i,
    input  logic [1:0]                      tlb_mat_i,
    output logic                            advance_ready_o,
    output logic                            req_valid_o,
    output logic                            req_we_o,
    output logic [mem_pkg::ADDR_W-1:0]      req_addr_o,
    output logic [3:0]                      req_sel_o,
    output mem_pkg::req_size_e              req_size_o,
    output logic [mem_pkg::ADDR_W-1:0]      req_data_o,
    output logic                            req_uncache_o,
    output logic                            out_valid_o,
    output mem_pkg::mem_op_e                out_op_o,
    output mem_pkg::excp_e                  out_excp_o,
    output logic [mem_pkg::ADDR_W-1:0]      out_paddr_o,
    output logic                            out_wreg_o,
    output logic [mem_pkg::ADDR_W-1:0]      out_wdata_o
);
    import mem_pkg::*;

    logic              hit;
    logic [PPN_W-1:0]  pg_ppn;
    logic              pg_v;
    logic              pg_d;
    logic [1:0]        pg_plv;
    logic [1:0]        pg_mat;
    logic [ADDR_W-1:0] paddr;
    logic              llbit;
    excp_e             excp;
    logic              uncache;
    logic [3:0]        sel;
    logic [ADDR_W-1:0] st_data;
    req_size_e         size;

    tlb_lookup #(
        .TLB_ENTRIES(TLB_ENTRIES)
    ) tlb_i (
        .clk(clk), .rst(rst), .vaddr_i(vaddr_i),
        .we_i(tlb_we_i), .widx_i(tlb_widx_i), .vppn_i(tlb_vppn_i), .ppn_i(tlb_ppn_i),
        .v_i(tlb_v_i), .d_i(tlb_d_i), .plv_i(tlb_plv_i), .mat_i(tlb_mat_i),
        .hit_o(hit), .ppn_o(pg_ppn), .v_o(pg_v), .d_o(pg_d), .plv_o(pg_plv), .mat_o(pg_mat)
    );

    // Direct mapping when translation is off
    assign paddr = trans_en_i ? {pg_ppn, vaddr_i[PAGE_BITS-1:0]} : vaddr_i;

    mem_excp_check excp_i_chk (
        .op_i(op_i), .llbit_i(llbit), .trans_en_i(trans_en_i), .plv_i(plv_i),
        .vaddr_msb_i(vaddr_i[ADDR_W-1]), .hit_i(hit), .pg_v_i(pg_v), .pg_d_i(pg_d),
        .pg_plv_i(pg_plv), .pg_mat_i(pg_mat), .uncache_i(uncache_i),
        .excp_o(excp), .uncache_o(uncache)
    );

    store_align align_i (
        .op_i(op_i), .ofs_i(vaddr_i[1:0]), .wdata_i(wdata_i),
        .sel_o(sel), .data_o(st_data), .size_o(size)
    );

    mem1_ctrl #(
        .LINE_OFS_BITS(LINE_OFS_BITS),
        .SET_BITS(SET_BITS)
    ) ctrl_i (
        .clk(clk), .rst(rst), .advance_i(advance_i), .flush_i(flush_i),
        .valid_i(valid_i), .op_i(op_i), .paddr_i(paddr), .excp_i(excp),
        .uncache_i(uncache), .sel_i(sel), .size_i(size), .data_i(st_data),
        .dcache_ready_i(dcache_ready_i), .llbit_o(llbit), .advance_ready_o(advance_ready_o),
        .req_valid_o(req_valid_o), .req_we_o(req_we_o), .req_addr_o(req_addr_o),
        .req_sel_o(req_sel_o), .req_size_o(req_size_o), .req_data_o(req_data_o),
        .req_uncache_o(req_uncache_o), .out_valid_o(out_valid_o), .out_op_o(out_op_o),
        .out_excp_o(out_excp_o), .out_paddr_o(out_paddr_o), .out_wreg_o(out_wreg_o),
        .out_wdata_o(out_wdata_o)
    );

endmodule

// ==== design/mem_excp_check.sv ====
`timescale 1ns/1ns

module mem_excp_check (
    input  mem_pkg::mem_op_e op_i,
    input  logic             llbit_i,
    input  logic             trans_en_i,
    input  logic [1:0]       plv_i,
    input  logic             vaddr_msb_i,
    input  logic             hit_i,
    input  logic             pg_v_i,
    input  logic             pg_d_i,
    input  logic [1:0]       pg_plv_i,
    input  logic [1:0]       pg_mat_i,
    input  logic             uncache_i,
    output mem_pkg::excp_e   excp_o,
    output logic             uncache_o
);
    import mem_pkg::*;

    logic is_load;
    logic is_store;
    logic is_mem;

    assign is_load = (op_i inside {OP_LD_B, OP_LD_BU, OP_LD_H, OP_LD_HU, OP_LD_W, OP_LL});
    // A failing SC never writes memory
    assign is_store = (op_i inside {OP_ST_B, OP_ST_H, OP_ST_W}) || (op_i == OP_SC && llbit_i);
    assign is_mem = is_load || is_store || (op_i == OP_SC);

    always_comb begin
        excp_o = EXC_NONE;
        if (is_mem && trans_en_i) begin
            if (plv_i == 2'd3 && vaddr_msb_i) begin
                excp_o = EXC_ADEM;
            end else if (!hit_i) begin
                excp_o = EXC_TLBR;
            end else if (is_load && !pg_v_i) begin
                excp_o = EXC_PIL;
            end else if (is_store && !pg_v_i) begin
                excp_o = EXC_PIS;
            end else if (pg_v_i && plv_i > pg_plv_i) begin
                excp_o = EXC_PPI;
            end else if (is_store && pg_v_i && !pg_d_i) begin
                excp_o = EXC_PME;
            end
        end
    end

    // Strongly ordered uncached pages have mat 0
    assign uncache_o = uncache_i || (trans_en_i && pg_mat_i == 2'd0);

endmodule

// ==== design/mem_pkg.sv ====
package mem_pkg;

    // Word and page geometry
    localparam int ADDR_W    = 32;
    localparam int PAGE_BITS = 12;
    localparam int PPN_W     = ADDR_W - PAGE_BITS;

    // Operations seen by the first memory stage
    typedef enum logic [3:0] {
        OP_NONE  = 4'd0,
        OP_LD_B  = 4'd1,
        OP_LD_BU = 4'd2,
        OP_LD_H  = 4'd3,
        OP_LD_HU = 4'd4,
        OP_LD_W  = 4'd5,
        OP_ST_B  = 4'd6,
        OP_ST_H  = 4'd7,
        OP_ST_W  = 4'd8,
        OP_LL    = 4'd9,
        OP_SC    = 4'd10
    } mem_op_e;

    // Listed from highest to lowest priority
    typedef enum logic [2:0] {
        EXC_NONE = 3'd0,
        EXC_ADEM = 3'd1,
        EXC_TLBR = 3'd2,
        EXC_PIL  = 3'd3,
        EXC_PIS  = 3'd4,
        EXC_PPI  = 3'd5,
        EXC_PME  = 3'd6
    } excp_e;

    // Cache request size
    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2
    } req_size_e;

endpackage

// ==== design/store_align.sv ====
`timescale 1ns/1ns

module store_align (
    input  mem_pkg::mem_op_e            op_i,
    input  logic [1:0]                  ofs_i,
    input  logic [mem_pkg::ADDR_W-1:0]  wdata_i,
    output logic [3:0]                  sel_o,
    output logic [mem_pkg::ADDR_W-1:0]  data_o,
    output mem_pkg::req_size_e          size_o
);
    import mem_pkg::*;

    logic [3:0]        lane_mask;
    logic [ADDR_W-1:0] lane_data;
    logic [4:0]        shamt;

    always_comb begin
        lane_mask = 4'b0000;
        lane_data = '0;
        size_o    = SZ_BYTE;
        case (op_i)
            OP_LD_B, OP_LD_BU: begin
                lane_mask = 4'b0001;
            end
            OP_LD_H, OP_LD_HU: begin
                lane_mask = 4'b0011;
                size_o    = SZ_HALF;
            end
            OP_LD_W, OP_LL: begin
                lane_mask = 4'b1111;
                size_o    = SZ_WORD;
            end
            OP_ST_B: begin
                lane_mask = 4'b0001;
                lane_data = {24'b0, wdata_i[7:0]};
            end
            OP_ST_H: begin
                lane_mask = 4'b0011;
                lane_data = {16'b0, wdata_i[15:0]};
                size_o    = SZ_HALF;
            end
            OP_ST_W, OP_SC: begin
                lane_mask = 4'b1111;
                lane_data = wdata_i;
                size_o    = SZ_WORD;
            end
            default: begin
            end
        endcase
    end

    // Byte offset times eight
    assign shamt  = {ofs_i, 3'b000};
    assign sel_o  = lane_mask << ofs_i;
    assign data_o = lane_data << shamt;

endmodule

// ==== design/tlb_lookup.sv ====
`timescale 1ns/1ns

module tlb_lookup #(
    parameter int TLB_ENTRIES = 8
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [mem_pkg::ADDR_W-1:0]          vaddr_i,
    input  logic                                we_i,
    input  logic [$clog2(TLB_ENTRIES)-1:0]      widx_i,
    input  logic [mem_pkg::PPN_W-1:0]           vppn_i,
    input  logic [mem_pkg::PPN_W-1:0]           ppn_i,
    input  logic                                v_i,
    input  logic                                d_i,
    input  logic [1:0]                          plv_i,
    input  logic [1:0]                          mat_i,
    output logic                                hit_o,
    output logic [mem_pkg::PPN_W-1:0]           ppn_o,
    output logic                                v_o,
    output logic                                d_o,
    output logic [1:0]                          plv_o,
    output logic [1:0]                          mat_o
);
    import mem_pkg::*;

    logic [TLB_ENTRIES-1:0] ent_valid;
    logic [PPN_W-1:0]       ent_vppn [TLB_ENTRIES];
    logic [PPN_W-1:0]       ent_ppn  [TLB_ENTRIES];
    logic                   ent_v    [TLB_ENTRIES];
    logic                   ent_d    [TLB_ENTRIES];
    logic [1:0]             ent_plv  [TLB_ENTRIES];
    logic [1:0]             ent_mat  [TLB_ENTRIES];

    always_ff @(posedge clk) begin
        if (rst) begin
            ent_valid <= '0;
        end else if (we_i) begin
            ent_valid[widx_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            ent_vppn[widx_i] <= vppn_i;
            ent_ppn[widx_i]  <= ppn_i;
            ent_v[widx_i]    <= v_i;
            ent_d[widx_i]    <= d_i;
            ent_plv[widx_i]  <= plv_i;
            ent_mat[widx_i]  <= mat_i;
        end
    end

    // Scan from the top down so the lowest matching entry wins
    always_comb begin
        hit_o = 1'b0;
        ppn_o = '0;
        v_o   = 1'b0;
        d_o   = 1'b0;
        plv_o = 2'd0;
        mat_o = 2'd0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (ent_valid[i] && (ent_vppn[i] == vaddr_i[ADDR_W-1:PAGE_BITS])) begin
                hit_o = 1'b1;
                ppn_o = ent_ppn[i];
                v_o   = ent_v[i];
                d_o   = ent_d[i];
                plv_o = ent_plv[i];
                mat_o = ent_mat[i];
            end
        end
    end

endmodule

// ==== filelist.f ====
design/mem_pkg.sv
design/tlb_lookup.sv
design/mem_excp_check.sv
design/store_align.sv
design/mem1_ctrl.sv
design/mem1_top.sv
tests/mem1_chk.sv
tests/mem1_tb.sv

// ==== tests/mem1_chk.sv ====
`timescale 1ns/1ns

module mem1_chk (
    input logic       clk,
    input logic       rst,
    input logic       dcache_ready_i,
    input logic       flush_i,
    input logic       req_valid_o,
    input logic [3:0] req_sel_o,
    input logic       out_valid_o,
    input logic       out_wreg_o
);

    // Cache not ready means no request
    assert property (@(posedge clk) disable iff (rst) !dcache_ready_i |-> !req_valid_o)
        else $error("request issued while dcache not ready");

    assert property (@(posedge clk) disable iff (rst) flush_i |=> !out_valid_o && !out_wreg_o)
        else $error("output register not cleared after flush");

    assert property (@(posedge clk) disable iff (rst) req_valid_o |-> req_sel_o != 4'b0000)
        else $error("request with empty byte select");

endmodule

bind mem1_top mem1_chk chk_i (
    .clk(clk),
    .rst(rst),
    .dcache_ready_i(dcache_ready_i),
    .flush_i(flush_i),
    .req_valid_o(req_valid_o),
    .req_sel_o(req_sel_o),
    .out_valid_o(out_valid_o),
    .out_wreg_o(out_wreg_o)
);

// ==== tests/mem1_tb.sv ====
`timescale 1ns/1ns

module mem1_tb;
    import mem_pkg::*;

    typedef struct {
        mem_op_e     op;
        logic [31:0] va;
        logic [1:0]  plv;
        logic        tr, un;
        int          lo;
        logic        fl, st, rq, we;
        logic [31:0] pa;
        logic [3:0]  sel;
        req_size_e   sz;
        logic        uc;
        excp_e       ex;
        logic        wr, wd;
    } row_t;

    logic clk = 1'b0, rst, valid, trans_en, uncache, advance, flush, ready;
    logic tlb_we, tlb_v, tlb_d;
    mem_op_e op;
    logic [31:0] vaddr, wdata, req_addr, req_data, out_paddr, out_wdata;
    logic [1:0] plv, tlb_plv, tlb_mat;
    logic [2:0] tlb_widx;
    logic [19:0] tlb_vppn, tlb_ppn;
    logic adv_rdy, req_valid, req_we, req_unc, out_valid, out_wreg;
    logic [3:0] req_sel;
    req_size_e req_size;
    mem_op_e out_op;
    excp_e out_excp;
    logic [31:0] seed = 32'hf2a3;
    row_t rows[$];

    mem1_top #(.TLB_ENTRIES(8), .LINE_OFS_BITS(4), .SET_BITS(6)) dut_i (
        .clk(clk), .rst(rst), .valid_i(valid), .op_i(op), .vaddr_i(vaddr), .wdata_i(wdata),
        .plv_i(plv), .trans_en_i(trans_en), .uncache_i(uncache), .advance_i(advance),
        .flush_i(flush), .dcache_ready_i(ready), .tlb_we_i(tlb_we), .tlb_widx_i(tlb_widx),
        .tlb_vppn_i(tlb_vppn), .tlb_ppn_i(tlb_ppn), .tlb_v_i(tlb_v), .tlb_d_i(tlb_d),
        .tlb_plv_i(tlb_plv), .tlb_mat_i(tlb_mat), .advance_ready_o(adv_rdy),
        .req_valid_o(req_valid), .req_we_o(req_we), .req_addr_o(req_addr),
        .req_sel_o(req_sel), .req_size_o(req_size), .req_data_o(req_data),
        .req_uncache_o(req_unc), .out_valid_o(out_valid), .out_op_o(out_op),
        .out_excp_o(out_excp), .out_paddr_o(out_paddr), .out_wreg_o(out_wreg),
        .out_wdata_o(out_wdata)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    task automatic abort(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "run stopped");
    endtask

    task automatic check_excp(input string name, input excp_e got, input excp_e exp);
        if (got !== exp)
            abort($sformatf("ERR %0t %s got %s exp %s", $time, name, got.name(), exp.name()));
    endtask

    task automatic check_size(input string name, input req_size_e got, input req_size_e exp);
        if (got !== exp)
            abort($sformatf("ERR %0t %s got %s exp %s", $time, name, got.name(), exp.name()));
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            abort($sformatf("ERR %0t %s got %h exp %h", $time, name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort($sformatf("ERR %0t %s got %b exp %b", $time, name, got, exp));
    endtask

    task automatic add_row(input mem_op_e op_v, input logic [31:0] va, input logic [1:0] pl,
                           input logic tr, un, input int lo, input logic fl, st, rq, we,
                           input logic [31:0] pa, input logic [3:0] sel, input req_size_e sz,
                           input logic uc, input excp_e ex, input logic wr, wd);
        row_t r;
        r = '{op_v, va, pl, tr, un, lo, fl, st, rq, we, pa, sel, sz, uc, ex, wr, wd};
        rows.push_back(r);
    endtask

    task automatic tlb_write(input int idx, input logic [19:0] vppn, ppn,
                             input logic v, d, input logic [1:0] pl, mat);
        @(posedge clk);
        tlb_we <= 1'b1;
        tlb_widx <= idx[2:0];
        tlb_vppn <= vppn;
        tlb_ppn <= ppn;
        tlb_v <= v;
        tlb_d <= d;
        tlb_plv <= pl;
        tlb_mat <= mat;
    endtask

    task automatic run_row(input row_t r);
        int lo;
        int n;
        logic [31:0] wd;
        logic [31:0] mask;
        logic [31:0] exp_d;
        wd = xorshift();
        mask = (r.sz == SZ_BYTE) ? 32'hff : (r.sz == SZ_HALF) ? 32'hffff : 32'hffff_ffff;
        exp_d = r.we ? ((wd & mask) << (8 * r.va[1:0])) : 32'h0;
        lo = r.lo;
        n = 0;
        @(posedge clk);
        valid <= 1'b1;
        op <= r.op;
        vaddr <= r.va;
        wdata <= wd;
        plv <= r.plv;
        trans_en <= r.tr;
        uncache <= r.un;
        ready <= (lo == 0);
        @(negedge clk);
        if (r.st)
            check_bit("advance_ready_o", adv_rdy, 1'b0);
        while (!adv_rdy) begin
            check_bit("req_valid_o", req_valid, 1'b0);
            @(posedge clk);
            if (lo > 0)
                lo--;
            if (lo == 0)
                ready <= 1'b1;
            n++;
            if (n > r.lo + 2)
                abort("access not accepted within three cycles of the cache becoming ready");
            @(negedge clk);
        end
        @(posedge clk);
        advance <= 1'b1;
        @(negedge clk);
        // Request fields in the advance cycle
        check_bit("req_valid_o", req_valid, r.rq);
        check_bit("req_we_o", req_we, r.we);
        check_word("req_addr_o", req_addr, r.rq ? r.pa : 32'h0);
        check_word("req_sel_o", {28'h0, req_sel}, r.rq ? {28'h0, r.sel} : 32'h0);
        check_size("req_size_o", req_size, r.rq ? r.sz : SZ_BYTE);
        check_word("req_data_o", req_data, exp_d);
        check_bit("req_uncache_o", req_unc, r.rq && r.uc);
        @(posedge clk);
        advance <= 1'b0;
        flush <= r.fl;
        @(negedge clk);
        // Same access still presented right after acceptance hits its own set
        check_bit("advance_ready_o", adv_rdy, 1'b0);
        check_bit("out_valid_o", out_valid, 1'b1);
        check_word("out_op_o", {28'h0, out_op}, {28'h0, r.op});
        check_excp("out_excp_o", out_excp, r.ex);
        check_word("out_paddr_o", out_paddr, r.pa);
        check_bit("out_wreg_o", out_wreg, r.wr);
        check_word("out_wdata_o", out_wdata, {31'h0, r.wd});
        if (r.fl) begin
            @(posedge clk);
            flush <= 1'b0;
            @(negedge clk);
            check_bit("out_valid_o", out_valid, 1'b0);
        end
    endtask

    initial begin
        rst = 1'b1;
        valid = 1'b0;
        op = OP_NONE;
        vaddr = '0;
        wdata = '0;
        plv = 2'd0;
        trans_en = 1'b0;
        uncache = 1'b0;
        advance = 1'b0;
        flush = 1'b0;
        ready = 1'b1;
        tlb_we = 1'b0;
        tlb_widx = '0;
        tlb_vppn = '0;
        tlb_ppn = '0;
        tlb_v = 1'b0;
        tlb_d = 1'b0;
        tlb_plv = 2'd0;
        tlb_mat = 2'd0;

        // Untranslated sizes and offsets
        add_row(OP_LD_B, 32'h101, 0, 0, 0, 0, 0, 0, 1, 0, 32'h101, 4'b0010, SZ_BYTE, 0,
                EXC_NONE, 1, 0);
        add_row(OP_LD_BU, 32'h223, 0, 0, 0, 0, 0, 0, 1, 0, 32'h223, 4'b1000, SZ_BYTE, 0,
                EXC_NONE, 1, 0);
        add_row(OP_LD_H, 32'h332, 0, 0, 0, 0, 0, 0, 1, 0, 32'h332, 4'b1100, SZ_HALF, 0,
                EXC_NONE, 1, 0);
        add_row(OP_LD_HU, 32'h140, 0, 0, 0, 0, 0, 0, 1, 0, 32'h140, 4'b0011, SZ_HALF, 0,
                EXC_NONE, 1, 0);
        add_row(OP_LD_W, 32'h250, 0, 0, 0, 0, 0, 0, 1, 0, 32'h250, 4'b1111, SZ_WORD, 0,
                EXC_NONE, 1, 0);
        add_row(OP_ST_B, 32'h363, 0, 0, 0, 0, 0, 0, 1, 1, 32'h363, 4'b1000, SZ_BYTE, 0,
                EXC_NONE, 0, 0);
        add_row(OP_ST_B, 32'h170, 0, 0, 0, 0, 0, 0, 1, 1, 32'h170, 4'b0001, SZ_BYTE, 0,
                EXC_NONE, 0, 0);
        add_row(OP_ST_H, 32'h282, 0, 0, 0, 0, 0, 0, 1, 1, 32'h282, 4'b1100, SZ_HALF, 0,
                EXC_NONE, 0, 0);
        add_row(OP_ST_W, 32'h390, 0, 0, 0, 0, 0, 0, 1, 1, 32'h390, 4'b1111, SZ_WORD, 0,
                EXC_NONE, 0, 0);
        add_row(OP_LD_B, 32'h3a0, 0, 0, 0, 0, 0, 0, 1, 0, 32'h3a0, 4'b0001, SZ_BYTE, 0,
                EXC_NONE, 1, 0);
        add_row(OP_LD_BU, 32'h3b2, 0, 0, 0, 0, 0, 0, 1, 0, 32'h3b2, 4'b0100, SZ_BYTE, 0,
                EXC_NONE, 1, 0);
        add_row(OP_ST_B, 32'h3c1, 0, 0, 0, 0, 0, 0, 1, 1, 32'h3c1, 4'b0010, SZ_BYTE, 0,
                EXC_NONE, 0, 0);
        add_row(OP_ST_B, 32'h3d2, 0, 0, 0, 0, 0, 0, 1, 1, 32'h3d2, 4'b0100, SZ_BYTE, 0,
                EXC_NONE, 0, 0);
        add_row(OP_ST_H, 32'h3e0, 0, 0, 0, 0, 0, 0, 1, 1, 32'h3e0, 4'b0011, SZ_HALF, 0,
                EXC_NONE, 0, 0);
        add_row(OP_LD_W, 32'h1a0, 0, 0, 1, 0, 0, 0, 1, 0, 32'h1a0, 4'b1111, SZ_WORD, 1,
                EXC_NONE, 1, 0);
        // Translated through the TLB
        add_row(OP_LD_W, 32'h1000_0124, 0, 1, 0, 0, 0, 0, 1, 0, 32'h8000_1124, 4'b1111,
                SZ_WORD, 0, EXC_NONE, 1, 0);
        add_row(OP_LD_W, 32'h1000_1238, 0, 1, 0, 0, 0, 0, 1, 0, 32'h8000_2238, 4'b1111,
                SZ_WORD, 1, EXC_NONE, 1, 0);
        add_row(OP_ST_H, 32'h1000_0342, 0, 1, 0, 0, 0, 0, 1, 1, 32'h8000_1342, 4'b1100,
                SZ_HALF, 0, EXC_NONE, 0, 0);
        // Exceptions, some with several conditions active
        add_row(OP_LD_W, 32'h8000_0400, 3, 1, 0, 0, 0, 0, 0, 0, 32'h400, 4'b1111, SZ_WORD, 0,
                EXC_ADEM, 0, 0);
        add_row(OP_LD_W, 32'h2000_0450, 0, 1, 0, 0, 0, 0, 0, 0, 32'h450, 4'b1111, SZ_WORD, 0,
                EXC_TLBR, 0, 0);
        add_row(OP_LD_W, 32'h1000_2460, 3, 1, 0, 0, 0, 0, 0, 0, 32'h8000_3460, 4'b1111,
                SZ_WORD, 0, EXC_PIL, 0, 0);
        add_row(OP_ST_W, 32'h1000_2470, 0, 1, 0, 0, 0, 0, 0, 0, 32'h8000_3470, 4'b1111,
                SZ_WORD, 0, EXC_PIS, 0, 0);
        add_row(OP_ST_W, 32'h1000_3480, 3, 1, 0, 0, 0, 0, 0, 0, 32'h8000_4480, 4'b1111,
                SZ_WORD, 0, EXC_PPI, 0, 0);
        add_row(OP_ST_W, 32'h1000_1490, 3, 1, 0, 0, 0, 0, 0, 0, 32'h8000_2490, 4'b1111,
                SZ_WORD, 0, EXC_PME, 0, 0);
        // LL then two SCs
        add_row(OP_LL, 32'h4a0, 0, 0, 0, 0, 0, 0, 1, 0, 32'h4a0, 4'b1111, SZ_WORD, 0,
                EXC_NONE, 1, 0);
        add_row(OP_SC, 32'h4b4, 0, 0, 0, 0, 0, 0, 1, 1, 32'h4b4, 4'b1111, SZ_WORD, 0,
                EXC_NONE, 1, 1);
        add_row(OP_SC, 32'h4c8, 0, 0, 0, 0, 0, 0, 0, 0, 32'h4c8, 4'b1111, SZ_WORD, 0,
                EXC_NONE, 1, 0);
        // Back-pressure, same-set hazard, flush
        add_row(OP_LD_W, 32'h5d0, 0, 0, 0, 3, 0, 0, 1, 0, 32'h5d0, 4'b1111, SZ_WORD, 0,
                EXC_NONE, 1, 0);
        add_row(OP_LD_W, 32'h5d4, 0, 0, 0, 0, 0, 1, 1, 0, 32'h5d4, 4'b1111, SZ_WORD, 0,
                EXC_NONE, 1, 0);
        add_row(OP_ST_W, 32'h6e0, 0, 0, 0, 0, 1, 0, 1, 1, 32'h6e0, 4'b1111, SZ_WORD, 0,
                EXC_NONE, 0, 0);

        fork
            begin
                #((rows.size() * 20 + 16 + 8) * 100);
                $display("Timeout: the test table did not finish in time");
                $display("*** FAILED ***");
                $fatal(1, "watchdog");
            end
        join_none

        repeat (16) @(posedge clk);
        rst <= 1'b0;
        tlb_write(0, 20'h10000, 20'h80001, 1, 1, 2'd3, 2'd1);
        tlb_write(1, 20'h10001, 20'h80002, 1, 0, 2'd3, 2'd0);
        tlb_write(2, 20'h10002, 20'h80003, 0, 0, 2'd3, 2'd1);
        tlb_write(3, 20'h10003, 20'h80004, 1, 1, 2'd0, 2'd1);
        @(posedge clk);
        tlb_we <= 1'b0;

        foreach (rows[i])
            run_row(rows[i]);

        $display("*** PASSED ***");
        $finish;
    end

endmodule
